// File: risc14Pkg.sv
package risc14Pkg;

	localparam int WordWidth = 14;
	localparam int LaneWidth = 7;
	localparam int RegAddrWidth = 4;
	localparam int RegCount = 16;

	typedef logic [WordWidth-1:0] wordT;

	// Opcode values as in the reference machine
	typedef enum logic [5:0] {
		OpCpy  = 6'b000010,
		OpAdd  = 6'b000101,
		OpSub  = 6'b000110,
		OpAddc = 6'b000111,
		OpSubc = 6'b001000,
		OpNot  = 6'b001011,
		OpAnd  = 6'b001100,
		OpOr   = 6'b001101,
		OpXor  = 6'b001110,
		OpSrl  = 6'b001111,
		OpSra  = 6'b010000,
		OpRotl = 6'b010001,
		OpRotr = 6'b010010,
		OpRrc  = 6'b010101,
		OpVadd = 6'b010111,
		OpVsub = 6'b011000,
		OpIn   = 6'b011011,
		OpOut  = 6'b011100,
		OpNop  = 6'b011101
	} opcodeT;

	typedef struct packed {
		opcodeT opcode;
		logic [RegAddrWidth-1:0] ri; // Destination and first source
		logic [RegAddrWidth-1:0] rj; // Second source, constant or shift count
	} instT;

	typedef struct packed {
		logic [LaneWidth-1:0] hi;
		logic [LaneWidth-1:0] lo;
	} laneT;

	// Scalar or two-lane view of one ALU word
	typedef union packed {
		wordT word;
		laneT lane;
	} aluWordT;

	// Bit 11 down to bit 0, same order as the reference SR
	typedef struct packed {
		logic c;
		logic n;
		logic v;
		logic z;
		logic hiC;
		logic hiN;
		logic hiV;
		logic hiZ;
		logic loC;
		logic loN;
		logic loV;
		logic loZ;
	} statusT;

	typedef struct packed {
		logic valid;
		instT inst;
		wordT a;
		wordT b;
	} stageT;

	typedef struct packed {
		logic valid;
		logic writeEn;
		logic isOut;
		logic [RegAddrWidth-1:0] dest;
		wordT result;
		statusT status;
	} retireT;

	typedef struct packed {
		wordT data;
		statusT status;
	} outBeatT;

	localparam wordT NopWord = 14'h3FFF; // Bubble encoding

endpackage

// File: regFile.sv
module regFile (
	input  logic Clock_not,
	input  logic rstN,
	input  logic writeEn,
	input  logic [risc14Pkg::RegAddrWidth-1:0] writeAddr,
	input  risc14Pkg::wordT writeData,
	input  logic [risc14Pkg::RegAddrWidth-1:0] readAddrA,
	input  logic [risc14Pkg::RegAddrWidth-1:0] readAddrB,
	output risc14Pkg::wordT readDataA,
	output risc14Pkg::wordT readDataB
);
	import risc14Pkg::*;

	wordT regs [RegCount];

	always_ff @(posedge Clock_not or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Write-through so the retiring result is seen at once
	assign readDataA = (writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: operandStage.sv
module operandStage #(
	parameter int SwitchWidth = 5
) (
	input  logic Clock_not,
	input  logic rstN,
	input  logic stall,
	input  logic instValid,
	input  risc14Pkg::instT inst,
	input  logic [SwitchWidth-1:0] switches,
	input  risc14Pkg::wordT readDataA,
	input  risc14Pkg::wordT readDataB,
	output logic [risc14Pkg::RegAddrWidth-1:0] readAddrA,
	output logic [risc14Pkg::RegAddrWidth-1:0] readAddrB,
	input  logic fwdValid,
	input  logic [risc14Pkg::RegAddrWidth-1:0] fwdDest,
	input  risc14Pkg::wordT fwdData,
	output risc14Pkg::stageT stage
);
	import risc14Pkg::*;

	localparam stageT Bubble = '{valid: 1'b0, inst: instT'(NopWord), a: '0, b: '0};

	wordT srcA;
	wordT srcB;
	wordT opA;
	wordT opB;

	assign readAddrA = inst.ri;
	assign readAddrB = inst.rj;

	// ALU stage result wins over the register file
	assign srcA = (fwdValid && fwdDest == inst.ri) ? fwdData : readDataA;
	assign srcB = (fwdValid && fwdDest == inst.rj) ? fwdData : readDataB;

	always_comb begin
		opA = srcA;
		opB = srcB;
		case (inst.opcode)
			OpCpy: begin
				opA = srcB; // Ri takes the value of Rj
			end
			OpAddc, OpSubc: begin
				opB = wordT'(inst.rj); // Unsigned 4-bit constant
			end
			OpIn: begin
				opA = wordT'(switches);
				opB = '0;
			end
			OpNot, OpSrl, OpSra, OpRotl, OpRotr, OpRrc: begin
				opB = '0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge Clock_not or negedge rstN) begin
		if (!rstN) begin
			stage <= Bubble;
		end else if (!stall) begin
			if (instValid) begin
				stage <= '{valid: 1'b1, inst: inst, a: opA, b: opB};
			end else begin
				stage <= Bubble;
			end
		end
	end

endmodule

// File: aluStage.sv
module aluStage (
	input  logic Clock_not,
	input  logic rstN,
	input  logic stall,
	input  risc14Pkg::stageT stage,
	input  risc14Pkg::statusT status,
	output logic fwdValid,
	output logic [risc14Pkg::RegAddrWidth-1:0] fwdDest,
	output risc14Pkg::wordT fwdData,
	output risc14Pkg::retireT retire
);
	import risc14Pkg::*;

	// Sign rule of the reference: operands agree in sign, result differs
	function automatic logic overflow(input logic aMsb, input logic bMsb, input logic rMsb);
		return (aMsb ~^ bMsb) & (aMsb ^ rMsb);
	endfunction

	// One 7-bit lane; returns C, N, V, Z and the lane result
	function automatic logic [10:0] laneCalc(
		input logic [LaneWidth-1:0] x,
		input logic [LaneWidth-1:0] y,
		input logic sub
	);
		logic [LaneWidth:0] r;
		if (sub)
			r = {1'b0, x} - {1'b0, y};
		else
			r = {1'b0, x} + {1'b0, y};
		return {r[LaneWidth], r[LaneWidth-1], overflow(x[LaneWidth-1], y[LaneWidth-1],
			r[LaneWidth-1]), r[LaneWidth-1:0] == '0, r[LaneWidth-1:0]};
	endfunction

	statusT curStatus;
	statusT nextStatus;
	aluWordT opA;
	aluWordT opB;
	aluWordT res;
	logic [WordWidth:0] sum;
	logic [WordWidth:0] rrcIn;
	logic [WordWidth:0] rrcOut;
	logic [10:0] hiCalc;
	logic [10:0] loCalc;
	logic [1:0] shamt;
	logic writeReg;

	// Flags of the instruction ahead are not in the status register yet
	assign curStatus = retire.valid ? retire.status : status;
	assign shamt = stage.inst.rj[1:0];

	always_comb begin
		opA.word = stage.a;
		opB.word = stage.b;
		res.word = stage.a; // CPY, IN and OUT pass through
		sum = '0;
		rrcIn = {curStatus.c, stage.a};
		rrcOut = '0;
		hiCalc = '0;
		loCalc = '0;
		nextStatus = curStatus;
		writeReg = 1'b1;
		case (stage.inst.opcode)
			OpAdd, OpAddc, OpSub, OpSubc: begin
				if (stage.inst.opcode inside {OpSub, OpSubc})
					sum = {1'b0, stage.a} - {1'b0, stage.b};
				else
					sum = {1'b0, stage.a} + {1'b0, stage.b};
				res.word = sum[WordWidth-1:0];
				nextStatus.c = sum[WordWidth];
				nextStatus.n = sum[WordWidth-1];
				nextStatus.v = overflow(stage.a[WordWidth-1], stage.b[WordWidth-1],
					sum[WordWidth-1]);
				nextStatus.z = (sum[WordWidth-1:0] == '0);
			end
			OpNot: res.word = ~stage.a;
			OpAnd: res.word = stage.a & stage.b;
			OpOr: res.word = stage.a | stage.b;
			OpXor: res.word = stage.a ^ stage.b;
			OpSrl: res.word = stage.a >> shamt;
			OpSra: res.word = wordT'($signed(stage.a) >>> shamt);
			OpRotl: res.word = (stage.a << shamt) | (stage.a >> (5'd14 - 5'(shamt)));
			OpRotr: res.word = (stage.a >> shamt) | (stage.a << (5'd14 - 5'(shamt)));
			OpRrc: begin
				// C sits above bit 13 and rotates with the word
				rrcOut = (rrcIn >> shamt) | (rrcIn << (5'd15 - 5'(shamt)));
				res.word = rrcOut[WordWidth-1:0];
				nextStatus.c = rrcOut[WordWidth];
			end
			OpVadd, OpVsub: begin
				hiCalc = laneCalc(opA.lane.hi, opB.lane.hi, stage.inst.opcode == OpVsub);
				loCalc = laneCalc(opA.lane.lo, opB.lane.lo, stage.inst.opcode == OpVsub);
				{nextStatus.hiC, nextStatus.hiN, nextStatus.hiV, nextStatus.hiZ} = hiCalc[10:7];
				{nextStatus.loC, nextStatus.loN, nextStatus.loV, nextStatus.loZ} = loCalc[10:7];
				res.lane.hi = hiCalc[6:0];
				res.lane.lo = loCalc[6:0];
			end
			OpCpy, OpIn: ;
			default: writeReg = 1'b0; // OUT, NOP and bubbles
		endcase
		if (stage.inst.opcode inside {OpNot, OpAnd, OpOr, OpXor}) begin
			nextStatus.n = res.word[WordWidth-1];
			nextStatus.z = (res.word == '0);
		end
	end

	// Next result goes straight back for a dependent instruction
	assign fwdValid = stage.valid & writeReg;
	assign fwdDest = stage.inst.ri;
	assign fwdData = res.word;

	always_ff @(posedge Clock_not or negedge rstN) begin
		if (!rstN) begin
			retire <= '0;
		end else if (!stall) begin
			retire <= '{
				valid: stage.valid,
				writeEn: writeReg,
				isOut: (stage.inst.opcode == OpOut),
				dest: stage.inst.ri,
				result: res.word,
				status: nextStatus
			};
		end
	end

endmodule

// File: retireStage.sv
module retireStage (
	input  logic Clock_not,
	input  logic rstN,
	input  logic outReady,
	input  risc14Pkg::retireT retire,
	output logic writeEn,
	output logic [risc14Pkg::RegAddrWidth-1:0] writeAddr,
	output risc14Pkg::wordT writeData,
	output risc14Pkg::statusT status,
	output logic stall,
	output logic outValid,
	output risc14Pkg::outBeatT outBeat
);

	logic retireGo;
	logic loadBeat;

	// Held beat blocks the whole pipeline
	assign stall = outValid & ~outReady;
	assign retireGo = retire.valid & ~stall;
	assign loadBeat = retireGo & retire.isOut;

	assign writeEn = retireGo & retire.writeEn;
	assign writeAddr = retire.dest;
	assign writeData = retire.result;

	always_ff @(posedge Clock_not or negedge rstN) begin
		if (!rstN) begin
			status <= '0;
		end else if (retireGo) begin
			status <= retire.status;
		end
	end

	always_ff @(posedge Clock_not or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (loadBeat) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0; // Beat taken
		end
	end

	always_ff @(posedge Clock_not) begin
		if (loadBeat) begin
			outBeat <= '{data: retire.result, status: retire.status};
		end
	end

endmodule

// File: risc14Core.sv
module risc14Core #(
	parameter int SwitchWidth = 5
) (
	input  logic Clock_not,
	input  logic rstN,
	input  logic instValid,
	input  risc14Pkg::instT inst,
	output logic instReady,
	input  logic [SwitchWidth-1:0] switches,
	output logic outValid,
	output risc14Pkg::outBeatT outBeat,
	input  logic outReady
);
	import risc14Pkg::*;

	logic stall;
	logic writeEn;
	logic [RegAddrWidth-1:0] writeAddr;
	wordT writeData;
	logic [RegAddrWidth-1:0] readAddrA;
	logic [RegAddrWidth-1:0] readAddrB;
	wordT readDataA;
	wordT readDataB;
	logic fwdValid;
	logic [RegAddrWidth-1:0] fwdDest;
	wordT fwdData;
	stageT stage;
	retireT retire;
	statusT status;

	assign instReady = ~stall;

	regFile regFile_inst (
		.Clock_not(Clock_not), .rstN(rstN),
		.writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
		.readAddrA(readAddrA), .readAddrB(readAddrB),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	operandStage #(.SwitchWidth(SwitchWidth)) operandStage_inst (
		.Clock_not(Clock_not), .rstN(rstN), .stall(stall),
		.instValid(instValid), .inst(inst), .switches(switches),
		.readDataA(readDataA), .readDataB(readDataB),
		.readAddrA(readAddrA), .readAddrB(readAddrB),
		.fwdValid(fwdValid), .fwdDest(fwdDest), .fwdData(fwdData),
		.stage(stage)
	);

	aluStage aluStage_inst (
		.Clock_not(Clock_not), .rstN(rstN), .stall(stall),
		.stage(stage), .status(status),
		.fwdValid(fwdValid), .fwdDest(fwdDest), .fwdData(fwdData),
		.retire(retire)
	);

	retireStage retireStage_inst (
		.Clock_not(Clock_not), .rstN(rstN), .outReady(outReady),
		.retire(retire),
		.writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
		.status(status), .stall(stall),
		.outValid(outValid), .outBeat(outBeat)
	);

endmodule

// File: risc14_assertions.sv
module risc14Assertions (
	input logic Clock_not,
	input logic rstN,
	input logic outValid,
	input logic outReady,
	input risc14Pkg::outBeatT outBeat
);

	resetQuiet: assert property (@(posedge Clock_not) !rstN |-> !outValid)
		else $error("outValid high during reset");

	// Waiting beat keeps its value until taken
	beatHeld: assert property (@(posedge Clock_not) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outBeat))
		else $error("outBeat changed or vanished while outReady was low");

endmodule

bind risc14Core risc14Assertions risc14Assertions_inst (.*);

// File: tbRisc14.sv
module tbRisc14;
	import risc14Pkg::*;

	localparam int SwitchWidth = 5;
	localparam int IdleLimit = 200; // Cycles without any transfer

	logic Clock_not;
	logic rstN;
	logic instValid;
	instT inst;
	logic instReady;
	logic [SwitchWidth-1:0] switches;
	logic outValid;
	outBeatT outBeat;
	logic outReady;

	logic [31:0] lfsr;
	wordT instQ [$];
	logic [SwitchWidth-1:0] switchQ [$];
	outBeatT expectQ [$];
	int sent;
	int idle;
	logic holding; // Beat was waiting on the last cycle
	outBeatT heldBeat;

	risc14Core #(.SwitchWidth(SwitchWidth)) risc14Core_inst (
		.Clock_not(Clock_not), .rstN(rstN),
		.instValid(instValid), .inst(inst), .instReady(instReady),
		.switches(switches),
		.outValid(outValid), .outBeat(outBeat), .outReady(outReady)
	);

	always #4 Clock_not = ~Clock_not;

	// Galois form, taps x^32 + x^30 + x^26 + x^25 + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic randomBit(output logic b);
		b = lfsr[0];
		lfsr = lfsrStep(lfsr);
	endtask

	task automatic stopWithError(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	// Records are whitespace separated, so a line may hold several
	task automatic loadTestData();
		int fd;
		int code;
		string tok;
		string rest;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [SwitchWidth-1:0] sw;
		outBeatT beat;
		sw = '0;
		fd = $fopen("risc14_testdata.txt", "r");
		if (fd == 0)
			stopWithError("Cannot open risc14_testdata.txt");
		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok == "#") begin
				code = $fgets(rest, fd);
			end else if (tok == "S") begin
				code = $fscanf(fd, "%h", v1);
				sw = v1[SwitchWidth-1:0]; // Holds for the following instructions
			end else if (tok == "I") begin
				code = $fscanf(fd, "%h", v1);
				instQ.push_back(v1[WordWidth-1:0]);
				switchQ.push_back(sw);
			end else if (tok == "E") begin
				code = $fscanf(fd, "%h %h", v1, v2);
				beat.data = v1[WordWidth-1:0];
				beat.status = statusT'(v2[11:0]);
				expectQ.push_back(beat);
			end else begin
				stopWithError($sformatf("Unknown record %s in risc14_testdata.txt", tok));
			end
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);
	endtask

	initial begin
		logic b;
		Clock_not = 1'b0;
		rstN = 1'b0;
		instValid = 1'b0;
		inst = instT'(NopWord);
		switches = '0;
		outReady = 1'b0;
		lfsr = 32'hD671_9317;
		sent = 0;
		idle = 0;
		holding = 1'b0;
		heldBeat = '0;
		loadTestData();
		repeat (10) @(negedge Clock_not);
		rstN = 1'b1;
		#1;
		assert (instReady && !outValid)
		else stopWithError("Core is not idle after reset");

		while (sent < instQ.size() || expectQ.size() > 0) begin
			@(negedge Clock_not);
			randomBit(b);
			outReady = b;
			randomBit(b);
			instValid = (sent < instQ.size()) && b;
			if (sent < instQ.size()) begin
				inst = instT'(instQ[sent]);
				switches = switchQ[sent];
			end
			#1; // Let the handshake outputs settle
			if (holding) begin
				assert (outValid)
				else stopWithError("Beat was lost while outReady was low");
				assert (outBeat == heldBeat)
				else stopWithError($sformatf("Fail outBeat held %h now %h", heldBeat, outBeat));
			end
			holding = outValid && !outReady;
			heldBeat = outBeat;
			idle++;
			if (outValid && outReady) begin
				assert (expectQ.size() > 0)
				else stopWithError("Core sent a beat that was not expected");
				assert (outBeat.data == expectQ[0].data)
				else stopWithError($sformatf("Fail outBeat.data got %h expected %h",
					outBeat.data, expectQ[0].data));
				assert (outBeat.status == expectQ[0].status)
				else stopWithError($sformatf("Fail outBeat.status got %h expected %h",
					outBeat.status, expectQ[0].status));
				void'(expectQ.pop_front());
				idle = 0;
			end
			if (instValid && instReady) begin
				sent++;
				idle = 0;
			end
			assert (idle < IdleLimit)
			else stopWithError("Timeout, the core stopped taking instructions or sending beats");
		end

		// No duplicate beat may follow the last one
		repeat (8) begin
			@(negedge Clock_not);
			instValid = 1'b0;
			outReady = 1'b1;
			#1;
			assert (!outValid)
			else stopWithError("Core sent a beat after the last expected one");
		end

		if (sent == instQ.size() && expectQ.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stopWithError("Test data was not fully used");
		end
	end

endmodule

// File: risc14_testdata.txt
# I word: instruction word (hex). S value: switch setting (hex) for the following I records
# E data status: expected OUT beat, data and status (hex), in beat order
S 15  I 1B10  I 1C10  E 0015 000
S 1F  I 1B20  I 0512  I 1C10  E 0034 000
I 0621  I 1C20  E 3FEB E00
I 071F  I 0813  I 1C10  E 0040 000
I 0231  I 0631  I 1C30  E 0000 100
I 0522  I 1C20  E 3FD6 C00
I 0B30  I 0C31  I 0E31  I 1C30  E 0000 900
I 0D32  I 1C30  E 3FD6 C00
I 0243  I 0F42  I 1C40  E 0FF5 C00
I 1033  I 1C30  E 3FFA C00
I 1141  I 1C40  E 1FEA C00
I 1243  I 1C40  E 13FD C00
I 0F10  I 1C10  E 0040 C00
I 1512  I 1C10  E 1010 400
I 1541  I 1C40  E 09FE C00
I 1743  I 1C40  E 0978 C8C
I 1834  I 1C30  E 3682 C42
I 1855  I 1C50  E 0000 C11
I 1D00  I 1C10  I 1C20  I 1C30  E 1010 C11  E 3FD6 C11  E 3682 C11

// File: tb.f
risc14Pkg.sv
regFile.sv
operandStage.sv
aluStage.sv
retireStage.sv
risc14Core.sv
risc14_assertions.sv
tbRisc14.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f tb.f --top-module tbRisc14 -o simTbRisc14 > build.log 2>&1 \
	&& ./obj_dir/simTbRisc14 > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
